// File: packet_pkg.sv
// Packet staging buffer shared definitions
// Controller state and write source encodings, default sizes

`default_nettype none

package packet_pkg;

    // Controller states
    typedef enum logic [1:0] {
        CNTL_IDLE       = 2'd0,
        CNTL_STREAM     = 2'd1,
        CNTL_WAIT_STALL = 2'd2,
        CNTL_DONE       = 2'd3
    } cntl_state_t;

    // Which writer owns the SRAM port this cycle
    typedef enum logic [1:0] {
        SRC_NONE = 2'd0,
        SRC_DP   = 2'd1,
        SRC_EDGE = 2'd2
    } wr_src_t;

    localparam int DEF_PACKET_W    = 32;
    // Buffer lines as a power of two
    localparam int DEF_DEPTH       = 16;
    localparam int DEF_NUM_EDGE_PE = 4;
    localparam int DEF_FIFO_DEPTH  = 4;

endpackage

`default_nettype wire

// File: packet_sram.sv
// Packet buffer memory
// Single port, write has the port when we is high,
// otherwise the addressed word is registered onto rdata

`timescale 1ns/1ps
`default_nettype none

module packet_sram #(
    parameter int PACKET_W = packet_pkg::DEF_PACKET_W,
    parameter int DEPTH    = packet_pkg::DEF_DEPTH,
    localparam int ADDR_W  = $clog2(DEPTH)
) (
    input  logic                clk,
    input  logic                we,
    input  logic [ADDR_W-1:0]   addr,
    input  logic [PACKET_W-1:0] wdata,
    output logic [PACKET_W-1:0] rdata
);

    logic [PACKET_W-1:0] mem [DEPTH];

    // One-cycle read latency
    // rdata keeps the last word read during a write
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end else begin
            rdata <= mem[addr];
        end
    end

endmodule

`default_nettype wire

// File: packet_cntl.sv
// Packet buffer controller
// Arbitrates datapath and edge PE writers onto the SRAM port,
// tracks write and read pointers, and moves stored packets
// into the output FIFO when no write needs the port

`timescale 1ns/1ps
`default_nettype none

module packet_cntl #(
    parameter int PACKET_W    = packet_pkg::DEF_PACKET_W,
    parameter int DEPTH       = packet_pkg::DEF_DEPTH,
    parameter int NUM_EDGE_PE = packet_pkg::DEF_NUM_EDGE_PE,
    localparam int ADDR_W     = $clog2(DEPTH)
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 dp_valid,
    input  logic [PACKET_W-1:0]                  dp_packet,
    input  logic [NUM_EDGE_PE-1:0]               edge_valid,
    input  logic [NUM_EDGE_PE-1:0][PACKET_W-1:0] edge_packet,
    input  logic                                 cntl_done,
    input  logic                                 replay,
    input  logic                                 fifo_stall,
    input  logic                                 fifo_full,
    output logic                                 sram_we,
    output logic [ADDR_W-1:0]                    sram_addr,
    output logic [PACKET_W-1:0]                  sram_wdata,
    output logic                                 fifo_push
);

    import packet_pkg::*;

    // Pointers carry one wrap bit above the address
    localparam int PTR_W = ADDR_W + 1;

    cntl_state_t         state;
    cntl_state_t         nx_state;
    wr_src_t             wr_src;

    logic [PTR_W-1:0]    wr_ptr;
    logic [PTR_W-1:0]    rd_ptr;
    logic                buf_empty;
    logic                buf_full;

    logic [PACKET_W-1:0] edge_sel;
    logic                write_en;
    logic                read_en;
    logic                wr_state;

    assign buf_empty = (wr_ptr == rd_ptr);
    assign buf_full  = (wr_ptr[ADDR_W] != rd_ptr[ADDR_W]) &&
                       (wr_ptr[ADDR_W-1:0] == rd_ptr[ADDR_W-1:0]);

    // Highest index valid edge PE wins
    always_comb begin
        edge_sel = edge_packet[0];
        for (int i = 1; i < NUM_EDGE_PE; i++) begin
            if (edge_valid[i]) begin
                edge_sel = edge_packet[i];
            end
        end
    end

    // Datapath beats every edge PE
    always_comb begin
        if (dp_valid) begin
            wr_src = SRC_DP;
        end else if (|edge_valid) begin
            wr_src = SRC_EDGE;
        end else begin
            wr_src = SRC_NONE;
        end
    end

    assign wr_state = (state == CNTL_STREAM) || (state == CNTL_WAIT_STALL);

    // A write always takes the port, a read only gets a free cycle
    assign write_en = wr_state && (wr_src != SRC_NONE) && !buf_full && !replay;
    assign read_en  = (state == CNTL_STREAM) && !write_en && !buf_empty &&
                      !fifo_full && !replay;

    assign sram_we    = write_en;
    assign sram_addr  = write_en ? wr_ptr[ADDR_W-1:0] : rd_ptr[ADDR_W-1:0];
    assign sram_wdata = (wr_src == SRC_DP) ? dp_packet : edge_sel;

    always_comb begin
        nx_state = state;
        case (state)
            CNTL_IDLE: begin
                nx_state = CNTL_STREAM;
            end
            CNTL_STREAM: begin
                if (cntl_done) begin
                    nx_state = CNTL_DONE;
                end else if (fifo_stall) begin
                    nx_state = CNTL_WAIT_STALL;
                end
            end
            CNTL_WAIT_STALL: begin
                if (cntl_done) begin
                    nx_state = CNTL_DONE;
                end else if (!fifo_stall) begin
                    nx_state = CNTL_STREAM;
                end
            end
            // Frozen until replay or reset
            CNTL_DONE: begin
                nx_state = CNTL_DONE;
            end
            default: begin
                nx_state = CNTL_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state     <= CNTL_IDLE;
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            fifo_push <= 1'b0;
        end else begin
            // Read data shows up a cycle later, push lines up with it
            fifo_push <= read_en;
            if (replay) begin
                state  <= CNTL_IDLE;
                wr_ptr <= '0;
                rd_ptr <= '0;
            end else begin
                state <= nx_state;
                if (write_en) begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
                if (read_en) begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: packet_fifo.sv
// Output FIFO for staged packets
// First-word-fall-through, valid/ready on the output side.
// Full goes high one entry early to absorb the SRAM read in flight

`timescale 1ns/1ps
`default_nettype none

module packet_fifo #(
    parameter int PACKET_W   = packet_pkg::DEF_PACKET_W,
    parameter int FIFO_DEPTH = packet_pkg::DEF_FIFO_DEPTH,
    localparam int ADDR_W    = $clog2(FIFO_DEPTH),
    localparam int CNT_W     = $clog2(FIFO_DEPTH + 1)
) (
    input  logic                clk,
    input  logic                reset,
    input  logic                push,
    input  logic [PACKET_W-1:0] push_data,
    output logic                full,
    output logic                out_valid,
    output logic [PACKET_W-1:0] out_packet,
    input  logic                out_ready
);

    logic [PACKET_W-1:0] mem [FIFO_DEPTH];
    logic [ADDR_W-1:0]   wr_idx;
    logic [ADDR_W-1:0]   rd_idx;
    logic [CNT_W-1:0]    count;
    logic                push_ok;
    logic                pop;

    assign out_valid  = (count != '0);
    assign out_packet = mem[rd_idx];
    assign full       = (count >= CNT_W'(FIFO_DEPTH - 1));

    assign pop     = out_valid && out_ready;
    assign push_ok = push && (count != CNT_W'(FIFO_DEPTH));

    // Payload storage
    always_ff @(posedge clk) begin
        if (push_ok) begin
            mem[wr_idx] <= push_data;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_idx <= '0;
            rd_idx <= '0;
            count  <= '0;
        end else begin
            if (push_ok) begin
                wr_idx <= wr_idx + 1'b1;
            end
            if (pop) begin
                rd_idx <= rd_idx + 1'b1;
            end
            case ({push_ok, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: packet_buffer_top.sv
// Packet staging buffer top level
// Controller, single-port SRAM and output FIFO

`timescale 1ns/1ps
`default_nettype none

module packet_buffer_top #(
    parameter int PACKET_W    = packet_pkg::DEF_PACKET_W,
    parameter int DEPTH       = packet_pkg::DEF_DEPTH,
    parameter int NUM_EDGE_PE = packet_pkg::DEF_NUM_EDGE_PE,
    parameter int FIFO_DEPTH  = packet_pkg::DEF_FIFO_DEPTH,
    localparam int ADDR_W     = $clog2(DEPTH)
) (
    input  logic                                 clk,
    input  logic                                 reset,
    input  logic                                 dp_valid,
    input  logic [PACKET_W-1:0]                  dp_packet,
    input  logic [NUM_EDGE_PE-1:0]               edge_valid,
    input  logic [NUM_EDGE_PE-1:0][PACKET_W-1:0] edge_packet,
    input  logic                                 cntl_done,
    input  logic                                 replay,
    input  logic                                 fifo_stall,
    input  logic                                 out_ready,
    output logic                                 out_valid,
    output logic [PACKET_W-1:0]                  out_packet
);

    logic                sram_we;
    logic [ADDR_W-1:0]   sram_addr;
    logic [PACKET_W-1:0] sram_wdata;
    logic [PACKET_W-1:0] sram_rdata;
    logic                fifo_push;
    logic                fifo_full;

    packet_cntl #(
        .PACKET_W    (PACKET_W),
        .DEPTH       (DEPTH),
        .NUM_EDGE_PE (NUM_EDGE_PE)
    ) cntl0 (
        .clk         (clk),
        .reset       (reset),
        .dp_valid    (dp_valid),
        .dp_packet   (dp_packet),
        .edge_valid  (edge_valid),
        .edge_packet (edge_packet),
        .cntl_done   (cntl_done),
        .replay      (replay),
        .fifo_stall  (fifo_stall),
        .fifo_full   (fifo_full),
        .sram_we     (sram_we),
        .sram_addr   (sram_addr),
        .sram_wdata  (sram_wdata),
        .fifo_push   (fifo_push)
    );

    packet_sram #(
        .PACKET_W (PACKET_W),
        .DEPTH    (DEPTH)
    ) sram0 (
        .clk   (clk),
        .we    (sram_we),
        .addr  (sram_addr),
        .wdata (sram_wdata),
        .rdata (sram_rdata)
    );

    // Registered SRAM read data meets the registered push here
    packet_fifo #(
        .PACKET_W   (PACKET_W),
        .FIFO_DEPTH (FIFO_DEPTH)
    ) fifo0 (
        .clk        (clk),
        .reset      (reset),
        .push       (fifo_push),
        .push_data  (sram_rdata),
        .full       (fifo_full),
        .out_valid  (out_valid),
        .out_packet (out_packet),
        .out_ready  (out_ready)
    );

endmodule

`default_nettype wire

// File: packet_buffer_properties.sv
// Controller properties, bound into every packet_cntl
// Read/write port sharing, FIFO room on push, replay return to idle

`timescale 1ns/1ps
`default_nettype none

module packet_buffer_properties (
    input logic                    clk,
    input logic                    reset,
    input logic                    replay,
    input logic                    sram_we,
    input logic                    fifo_push,
    input logic                    fifo_full,
    input packet_pkg::cntl_state_t state
);

    import packet_pkg::*;

    int fail_count;

    initial fail_count = 0;

    // A push only follows a read cycle, never a write
    push_after_read: assert property (@(posedge clk) disable iff (reset)
        fifo_push |-> !$past(sram_we))
        else begin
            fail_count = fail_count + 1;
            $error("fifo_push after a cycle that wrote the SRAM");
        end

    // Read was issued with room left in the FIFO
    push_with_room: assert property (@(posedge clk) disable iff (reset)
        fifo_push |-> !$past(fifo_full))
        else begin
            fail_count = fail_count + 1;
            $error("fifo_push after a read issued with fifo_full high");
        end

    replay_to_idle: assert property (@(posedge clk) disable iff (reset)
        replay |=> (state == CNTL_IDLE))
        else begin
            fail_count = fail_count + 1;
            $error("controller not idle the cycle after replay");
        end

endmodule

bind packet_cntl packet_buffer_properties props0 (
    .clk       (clk),
    .reset     (reset),
    .replay    (replay),
    .sram_we   (sram_we),
    .fifo_push (fifo_push),
    .fifo_full (fifo_full),
    .state     (state)
);

`default_nettype wire

// File: tb_packet_buffer.sv
// Directed testbench for the packet staging buffer
// Model queue of stored packets, checked on every output transfer

`timescale 1ns/1ps
`default_nettype none

module tb_packet_buffer;

    import packet_pkg::*;

    localparam int PACKET_W    = DEF_PACKET_W;
    localparam int DEPTH       = DEF_DEPTH;
    localparam int NUM_EDGE_PE = DEF_NUM_EDGE_PE;
    localparam int FIFO_DEPTH  = DEF_FIFO_DEPTH;

    logic                                 clk;
    logic                                 reset;
    logic                                 dp_valid;
    logic [PACKET_W-1:0]                  dp_packet;
    logic [NUM_EDGE_PE-1:0]               edge_valid;
    logic [NUM_EDGE_PE-1:0][PACKET_W-1:0] edge_packet;
    logic                                 cntl_done;
    logic                                 replay;
    logic                                 fifo_stall;
    logic                                 out_ready;
    logic                                 out_valid;
    logic [PACKET_W-1:0]                  out_packet;

    logic [PACKET_W-1:0] expected[$];
    logic [PACKET_W-1:0] head;
    logic [31:0]         rng_state;

    packet_buffer_top #(
        .PACKET_W    (PACKET_W),
        .DEPTH       (DEPTH),
        .NUM_EDGE_PE (NUM_EDGE_PE),
        .FIFO_DEPTH  (FIFO_DEPTH)
    ) dut0 (
        .clk         (clk),
        .reset       (reset),
        .dp_valid    (dp_valid),
        .dp_packet   (dp_packet),
        .edge_valid  (edge_valid),
        .edge_packet (edge_packet),
        .cntl_done   (cntl_done),
        .replay      (replay),
        .fifo_stall  (fifo_stall),
        .out_ready   (out_ready),
        .out_valid   (out_valid),
        .out_packet  (out_packet)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1, "stopping at first error");
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    task automatic next_packet(output logic [PACKET_W-1:0] pkt);
        rng_state = xorshift(rng_state);
        pkt = rng_state;
    endtask

    // Inputs change 2 ns after the rising edge
    task automatic tick();
        @(posedge clk);
        #2;
    endtask

    task automatic write_dp(input logic [PACKET_W-1:0] pkt, input bit stored);
        dp_valid  = 1'b1;
        dp_packet = pkt;
        if (stored) begin
            expected.push_back(pkt);
        end
        tick();
        dp_valid = 1'b0;
    endtask

    task automatic drain_expected(input int max_cycles);
        int cycles;
        cycles = 0;
        while (expected.size() != 0 && cycles < max_cycles) begin
            tick();
            cycles++;
        end
        assert (expected.size() == 0) else begin
            report_failure($sformatf("Timed out waiting for out_valid, %0d packets missing",
                                     expected.size()));
        end
    endtask

    task automatic check_quiet(input int n);
        for (int i = 0; i < n; i++) begin
            tick();
            assert (out_valid == 1'b0) else begin
                report_failure($sformatf("Mismatch at %0t: out_valid expected 0 got %b",
                                         $time, out_valid));
            end
        end
    endtask

    // Each output transfer is checked mid-cycle where outputs are settled
    always @(negedge clk) begin
        assert (dut0.cntl0.props0.fail_count == 0) else begin
            report_failure("A controller property failed");
        end
        if (!reset && out_valid && out_ready) begin
            assert (expected.size() != 0) else begin
                report_failure($sformatf("Packet %h came out with nothing expected at %0t",
                                         out_packet, $time));
            end
            head = expected.pop_front();
            assert (out_packet == head) else begin
                report_failure($sformatf("Mismatch at %0t: out_packet expected %h got %h",
                                         $time, head, out_packet));
            end
        end
    end

    task automatic stream_order();
        logic [PACKET_W-1:0] pkt;
        for (int i = 0; i < 8; i++) begin
            next_packet(pkt);
            write_dp(pkt, 1'b1);
        end
        drain_expected(100);
    endtask

    task automatic write_priority();
        logic [PACKET_W-1:0] pkt;
        for (int i = 0; i < NUM_EDGE_PE; i++) begin
            next_packet(pkt);
            edge_packet[i] = pkt;
        end
        next_packet(pkt);
        // Datapath beats edge PEs 0 and 2
        edge_valid = 4'b0101;
        write_dp(pkt, 1'b1);
        // PE 2 beats PE 1
        edge_valid = 4'b0110;
        expected.push_back(edge_packet[2]);
        tick();
        edge_valid = '0;
        drain_expected(50);
    endtask

    task automatic buffer_full();
        logic [PACKET_W-1:0] pkt;
        int kept;
        kept = FIFO_DEPTH - 1 + DEPTH;
        out_ready = 1'b0;
        // Idle cycle after each write leaves room for a read
        for (int i = 0; i < DEPTH + FIFO_DEPTH + 4; i++) begin
            next_packet(pkt);
            write_dp(pkt, i < kept);
            tick();
        end
        out_ready = 1'b1;
        drain_expected(200);
        check_quiet(10);
    endtask

    task automatic stall_hold();
        logic [PACKET_W-1:0] pkt;
        fifo_stall = 1'b1;
        tick();
        for (int i = 0; i < 5; i++) begin
            next_packet(pkt);
            write_dp(pkt, 1'b1);
        end
        check_quiet(12);
        fifo_stall = 1'b0;
        drain_expected(100);
    endtask

    task automatic done_and_replay();
        logic [PACKET_W-1:0] pkt;
        cntl_done = 1'b1;
        tick();
        cntl_done = 1'b0;
        for (int i = 0; i < 4; i++) begin
            next_packet(pkt);
            write_dp(pkt, 1'b0);
        end
        check_quiet(10);
        replay = 1'b1;
        tick();
        replay = 1'b0;
        // Controller sits in idle for one cycle
        tick();
        for (int i = 0; i < 4; i++) begin
            next_packet(pkt);
            write_dp(pkt, 1'b1);
        end
        drain_expected(100);
    endtask

    initial begin
        rng_state   = 32'hbade;
        reset       = 1'b1;
        dp_valid    = 1'b0;
        dp_packet   = '0;
        edge_valid  = '0;
        edge_packet = '0;
        cntl_done   = 1'b0;
        replay      = 1'b0;
        fifo_stall  = 1'b0;
        out_ready   = 1'b1;
        repeat (3) @(posedge clk);
        #2;
        reset = 1'b0;
        tick();
        tick();
        stream_order();
        write_priority();
        buffer_full();
        stall_hold();
        done_and_replay();
        assert (dut0.cntl0.props0.fail_count == 0) else begin
            report_failure("A controller property failed");
        end
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: sim.f
packet_pkg.sv
packet_sram.sv
packet_cntl.sv
packet_fifo.sv
packet_buffer_top.sv
packet_buffer_properties.sv
tb_packet_buffer.sv

// File: Makefile
# Verilator build for the packet staging buffer

VERILATOR  ?= verilator
TB_TOP     ?= tb_packet_buffer
RTL_TOP    ?= packet_buffer_top
FILELIST   ?= sim.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
PASS_MSG   ?= Simulation passed
RTL_FILES  ?= packet_pkg.sv packet_sram.sv packet_cntl.sv packet_fifo.sv packet_buffer_top.sv
LINT_FLAGS ?= --lint-only -Wall
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) $(RTL_FILES)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TB_TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TB_TOP) 2>&1 | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
